/* rv_decode_pkg.sv */
/*
 shared widths, opcodes and decode info bit positions for the RV32I decode stage.
 info bits 2..0 always hold the group code. Upper bits unused by a group stay zero.
 */
package rv_decode_pkg;

    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DECINFO_W  = 17;
    localparam int GRP_W      = 3;

    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [INST_W-1:0]     word_t;     // address or immediate
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DECINFO_W-1:0]  dec_info_t;
    typedef logic [GRP_W-1:0]      grp_t;

    // base opcodes, bits 6..0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

    localparam grp_t GRP_NONE = 3'd0;
    localparam grp_t GRP_ALU  = 3'd1;
    localparam grp_t GRP_BJP  = 3'd2;
    localparam grp_t GRP_MEM  = 3'd3;

    localparam int INFO_GRP_MSB = GRP_W - 1;

    // alu group
    localparam int INFO_ALU_LUI    = 3;
    localparam int INFO_ALU_AUIPC  = 4;
    localparam int INFO_ALU_ADD    = 5;
    localparam int INFO_ALU_SUB    = 6;
    localparam int INFO_ALU_SLL    = 7;
    localparam int INFO_ALU_SLT    = 8;
    localparam int INFO_ALU_SLTU   = 9;
    localparam int INFO_ALU_XOR    = 10;
    localparam int INFO_ALU_SRL    = 11;
    localparam int INFO_ALU_SRA    = 12;
    localparam int INFO_ALU_OR     = 13;
    localparam int INFO_ALU_AND    = 14;
    localparam int INFO_ALU_OP2IMM = 15;
    localparam int INFO_ALU_OP1PC  = 16;

    // branch / jump group
    localparam int INFO_BJP_JUMP   = 3;
    localparam int INFO_BJP_BEQ    = 4;
    localparam int INFO_BJP_BNE    = 5;
    localparam int INFO_BJP_BLT    = 6;
    localparam int INFO_BJP_BGE    = 7;
    localparam int INFO_BJP_BLTU   = 8;
    localparam int INFO_BJP_BGEU   = 9;
    localparam int INFO_BJP_OP1RS1 = 10;

    // memory group
    localparam int INFO_MEM_LB       = 3;
    localparam int INFO_MEM_LH       = 4;
    localparam int INFO_MEM_LW       = 5;
    localparam int INFO_MEM_LBU      = 6;
    localparam int INFO_MEM_LHU      = 7;
    localparam int INFO_MEM_SB       = 8;
    localparam int INFO_MEM_SH       = 9;
    localparam int INFO_MEM_SW       = 10;
    localparam int INFO_MEM_OP_LOAD  = 11;
    localparam int INFO_MEM_OP_STORE = 12;

endpackage

/* dec_fields_if.sv */
/*
 split instruction fields plus one-hot opcode class flags.
 class flags are exclusive, at most one is high for any instruction.
 */
`timescale 1ns/1ns

interface dec_fields_if;

    rv_decode_pkg::inst_t     inst;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    rv_decode_pkg::reg_addr_t rd;
    rv_decode_pkg::reg_addr_t rs1;
    rv_decode_pkg::reg_addr_t rs2;

    logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic is_load, is_store, is_opimm, is_op;

    modport producer (
        output inst, opcode, funct3, funct7, rd, rs1, rs2,
        output is_lui, is_auipc, is_jal, is_jalr, is_branch,
        output is_load, is_store, is_opimm, is_op
    );

    modport consumer (
        input inst, opcode, funct3, funct7, rd, rs1, rs2,
        input is_lui, is_auipc, is_jal, is_jalr, is_branch,
        input is_load, is_store, is_opimm, is_op
    );

endinterface

/* dec_field_split.sv */
/*
 combinational field splitter. Only the nine RV32I base opcodes get a class flag,
 anything else (system, fence, amo) leaves every flag low.
 */
`timescale 1ns/1ns

module dec_field_split (
    input  rv_decode_pkg::inst_t inst_i,
    dec_fields_if.producer       fields
);

    logic [6:0] opcode;

    assign opcode = inst_i[6:0];

    // raw fields, valid or not
    assign fields.inst   = inst_i;
    assign fields.opcode = opcode;
    assign fields.funct3 = inst_i[14:12];
    assign fields.funct7 = inst_i[31:25];
    assign fields.rd     = inst_i[11:7];
    assign fields.rs1    = inst_i[19:15];
    assign fields.rs2    = inst_i[24:20];

    // opcode class
    assign fields.is_lui    = (opcode == rv_decode_pkg::OPC_LUI);
    assign fields.is_auipc  = (opcode == rv_decode_pkg::OPC_AUIPC);
    assign fields.is_jal    = (opcode == rv_decode_pkg::OPC_JAL);
    assign fields.is_jalr   = (opcode == rv_decode_pkg::OPC_JALR);
    assign fields.is_branch = (opcode == rv_decode_pkg::OPC_BRANCH);
    assign fields.is_load   = (opcode == rv_decode_pkg::OPC_LOAD);
    assign fields.is_store  = (opcode == rv_decode_pkg::OPC_STORE);
    assign fields.is_opimm  = (opcode == rv_decode_pkg::OPC_OPIMM);
    assign fields.is_op     = (opcode == rv_decode_pkg::OPC_OP);

endmodule

/* imm_gen.sv */
/*
 immediate builder, selected by opcode class alone.
 funct fields are not checked here, so an illegal funct3 still yields its class format.
 */
`timescale 1ns/1ns

module imm_gen (
    dec_fields_if.consumer       fields,
    output rv_decode_pkg::word_t imm_o
);

    rv_decode_pkg::word_t imm_u, imm_j, imm_i, imm_b, imm_s, imm_sh;
    logic                 is_shift;

    assign imm_u  = {fields.inst[31:12], 12'b0};
    assign imm_j  = {{12{fields.inst[31]}}, fields.inst[19:12], fields.inst[20],
                     fields.inst[30:21], 1'b0};
    assign imm_i  = {{20{fields.inst[31]}}, fields.inst[31:20]};
    assign imm_b  = {{20{fields.inst[31]}}, fields.inst[7], fields.inst[30:25],
                     fields.inst[11:8], 1'b0};
    assign imm_s  = {{20{fields.inst[31]}}, fields.inst[31:25], fields.inst[11:7]};
    assign imm_sh = {27'b0, fields.inst[24:20]};  // shamt, zero-extended

    assign is_shift = fields.is_opimm && (fields.funct3 == 3'b001 || fields.funct3 == 3'b101);

    always_comb begin
        if (fields.is_lui || fields.is_auipc) begin
            imm_o = imm_u;
        end else if (fields.is_jal) begin
            imm_o = imm_j;
        end else if (is_shift) begin
            imm_o = imm_sh;
        end else if (fields.is_jalr || fields.is_load || fields.is_opimm) begin
            imm_o = imm_i;
        end else if (fields.is_branch) begin
            imm_o = imm_b;
        end else if (fields.is_store) begin
            imm_o = imm_s;
        end else begin
            imm_o = '0;
        end
    end

endmodule

/* alu_decode.sv */
/*
 ALU group decode: LUI, AUIPC, OP-IMM and OP.
 register and immediate forms share one op bit, OP2IMM tells them apart.
 */
`timescale 1ns/1ns

module alu_decode (
    dec_fields_if.consumer           fields,
    output logic                     hit_o,
    output rv_decode_pkg::dec_info_t info_o
);

    logic f7_base, f7_alt;
    logic op_ok;     // OP with a legal funct7
    logic arith_ok;  // non-shift ops
    logic shift_ok;

    assign f7_base = (fields.funct7 == rv_decode_pkg::F7_BASE);
    assign f7_alt  = (fields.funct7 == rv_decode_pkg::F7_ALT);

    // alt funct7 only legal with add/sub and srl/sra
    assign op_ok    = fields.is_op && (f7_base ||
                      (f7_alt && (fields.funct3 == 3'b000 || fields.funct3 == 3'b101)));
    assign arith_ok = op_ok || fields.is_opimm;
    assign shift_ok = op_ok || (fields.is_opimm && (f7_base ||
                      (f7_alt && fields.funct3 == 3'b101)));

    always_comb begin
        info_o = '0;
        info_o[rv_decode_pkg::INFO_GRP_MSB:0] = rv_decode_pkg::GRP_ALU;
        info_o[rv_decode_pkg::INFO_ALU_LUI]   = fields.is_lui;
        info_o[rv_decode_pkg::INFO_ALU_AUIPC] = fields.is_auipc;
        case (fields.funct3)
            3'b000: begin
                info_o[rv_decode_pkg::INFO_ALU_ADD] = arith_ok && !(fields.is_op && f7_alt);
                info_o[rv_decode_pkg::INFO_ALU_SUB] = op_ok && f7_alt;
            end
            3'b001: info_o[rv_decode_pkg::INFO_ALU_SLL]  = shift_ok;
            3'b010: info_o[rv_decode_pkg::INFO_ALU_SLT]  = arith_ok;
            3'b011: info_o[rv_decode_pkg::INFO_ALU_SLTU] = arith_ok;
            3'b100: info_o[rv_decode_pkg::INFO_ALU_XOR]  = arith_ok;
            3'b101: begin
                info_o[rv_decode_pkg::INFO_ALU_SRL] = shift_ok && f7_base;
                info_o[rv_decode_pkg::INFO_ALU_SRA] = shift_ok && f7_alt;
            end
            3'b110: info_o[rv_decode_pkg::INFO_ALU_OR]   = arith_ok;
            default: info_o[rv_decode_pkg::INFO_ALU_AND] = arith_ok;
        endcase
        info_o[rv_decode_pkg::INFO_ALU_OP2IMM] = fields.is_opimm || fields.is_lui ||
                                                 fields.is_auipc;
        info_o[rv_decode_pkg::INFO_ALU_OP1PC]  = fields.is_auipc;
    end

    // OP2IMM / OP1PC alone do not count as a hit
    assign hit_o = |info_o[rv_decode_pkg::INFO_ALU_AND:rv_decode_pkg::INFO_ALU_LUI];

endmodule

/* bjp_decode.sv */
/*
 branch and jump decode. JALR needs funct3 000,
 branch funct3 010 and 011 are reserved and give no hit.
 */
`timescale 1ns/1ns

module bjp_decode (
    dec_fields_if.consumer           fields,
    output logic                     hit_o,
    output rv_decode_pkg::dec_info_t info_o
);

    logic jalr_ok;

    assign jalr_ok = fields.is_jalr && (fields.funct3 == 3'b000);

    always_comb begin
        info_o = '0;  // bits above OP1RS1 stay zero
        info_o[rv_decode_pkg::INFO_GRP_MSB:0]   = rv_decode_pkg::GRP_BJP;
        info_o[rv_decode_pkg::INFO_BJP_JUMP]   = fields.is_jal || jalr_ok;
        info_o[rv_decode_pkg::INFO_BJP_BEQ]    = fields.is_branch && fields.funct3 == 3'b000;
        info_o[rv_decode_pkg::INFO_BJP_BNE]    = fields.is_branch && fields.funct3 == 3'b001;
        info_o[rv_decode_pkg::INFO_BJP_BLT]    = fields.is_branch && fields.funct3 == 3'b100;
        info_o[rv_decode_pkg::INFO_BJP_BGE]    = fields.is_branch && fields.funct3 == 3'b101;
        info_o[rv_decode_pkg::INFO_BJP_BLTU]   = fields.is_branch && fields.funct3 == 3'b110;
        info_o[rv_decode_pkg::INFO_BJP_BGEU]   = fields.is_branch && fields.funct3 == 3'b111;
        info_o[rv_decode_pkg::INFO_BJP_OP1RS1] = jalr_ok;  // target base is rs1
    end

    assign hit_o = |info_o[rv_decode_pkg::INFO_BJP_BGEU:rv_decode_pkg::INFO_BJP_JUMP];

endmodule

/* mem_decode.sv */
/*
 load / store decode. Only byte, half and word widths of RV32I,
 the unused load funct3 codes (011, 110, 111) and store codes above 010 miss.
 */
`timescale 1ns/1ns

module mem_decode (
    dec_fields_if.consumer           fields,
    output logic                     hit_o,
    output rv_decode_pkg::dec_info_t info_o
);

    logic ld_hit, st_hit;

    always_comb begin
        info_o = '0;
        info_o[rv_decode_pkg::INFO_GRP_MSB:0] = rv_decode_pkg::GRP_MEM;
        info_o[rv_decode_pkg::INFO_MEM_LB]  = fields.is_load && fields.funct3 == 3'b000;
        info_o[rv_decode_pkg::INFO_MEM_LH]  = fields.is_load && fields.funct3 == 3'b001;
        info_o[rv_decode_pkg::INFO_MEM_LW]  = fields.is_load && fields.funct3 == 3'b010;
        info_o[rv_decode_pkg::INFO_MEM_LBU] = fields.is_load && fields.funct3 == 3'b100;
        info_o[rv_decode_pkg::INFO_MEM_LHU] = fields.is_load && fields.funct3 == 3'b101;
        info_o[rv_decode_pkg::INFO_MEM_SB]  = fields.is_store && fields.funct3 == 3'b000;
        info_o[rv_decode_pkg::INFO_MEM_SH]  = fields.is_store && fields.funct3 == 3'b001;
        info_o[rv_decode_pkg::INFO_MEM_SW]  = fields.is_store && fields.funct3 == 3'b010;
        info_o[rv_decode_pkg::INFO_MEM_OP_LOAD]  = ld_hit;
        info_o[rv_decode_pkg::INFO_MEM_OP_STORE] = st_hit;
    end

    // op bits only on a matched width
    assign ld_hit = fields.is_load && (fields.funct3 inside {3'b000, 3'b001, 3'b010,
                                                             3'b100, 3'b101});
    assign st_hit = fields.is_store && (fields.funct3 inside {3'b000, 3'b001, 3'b010});
    assign hit_o  = ld_hit || st_hit;

endmodule

/* reg_access.sv */
/*
 register file addressing by opcode class. Unused addresses read as 0,
 writes to x0 are suppressed so reg_we_o never targets x0.
 */
`timescale 1ns/1ns

module reg_access (
    dec_fields_if.consumer           fields,
    output rv_decode_pkg::reg_addr_t reg1_raddr_o,
    output rv_decode_pkg::reg_addr_t reg2_raddr_o,
    output rv_decode_pkg::reg_addr_t reg_waddr_o,
    output logic                     reg_we_o
);

    logic use_rs1, use_rs2, use_rd;

    assign use_rs1 = fields.is_jalr || fields.is_branch || fields.is_load ||
                     fields.is_store || fields.is_opimm || fields.is_op;
    assign use_rs2 = fields.is_op || fields.is_store || fields.is_branch;

    // no write for branch / store
    assign use_rd  = (fields.is_lui || fields.is_auipc || fields.is_jal || fields.is_jalr ||
                      fields.is_load || fields.is_opimm || fields.is_op) &&
                     (fields.rd != '0);

    assign reg1_raddr_o = use_rs1 ? fields.rs1 : '0;
    assign reg2_raddr_o = use_rs2 ? fields.rs2 : '0;
    assign reg_waddr_o  = use_rd ? fields.rd : '0;
    assign reg_we_o     = use_rd;

endmodule

/* decode_stage.sv */
/*
 registered RV32I decode stage, one cycle from inst_valid_i to dec_valid_o.
 no back-pressure, every strobe is taken. Data outputs hold between strobes,
 illegal covers M, CSR, system and fence opcodes too.
 */
`timescale 1ns/1ns

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_i,
    input  rv_decode_pkg::inst_t      inst_i,
    input  rv_decode_pkg::word_t      inst_addr_i,
    input  logic                      inst_valid_i,
    output logic                      dec_valid_o,
    output rv_decode_pkg::dec_info_t  dec_info_o,
    output rv_decode_pkg::word_t      dec_imm_o,
    output rv_decode_pkg::word_t      inst_addr_o,
    output rv_decode_pkg::reg_addr_t  reg1_raddr_o,
    output rv_decode_pkg::reg_addr_t  reg2_raddr_o,
    output rv_decode_pkg::reg_addr_t  reg_waddr_o,
    output logic                      reg_we_o,
    output logic                      illegal_inst_o
);

    dec_fields_if fields ();

    rv_decode_pkg::dec_info_t  alu_info, bjp_info, mem_info, info_mrg;
    logic                      alu_hit, bjp_hit, mem_hit;
    logic                      illegal;
    rv_decode_pkg::word_t      imm;
    rv_decode_pkg::reg_addr_t  rs1_addr, rs2_addr, rd_addr;
    logic                      rd_we;

    dec_field_split u_split (
        .inst_i (inst_i),
        .fields (fields.producer)
    );

    imm_gen u_imm (
        .fields (fields.consumer),
        .imm_o  (imm)
    );

    alu_decode u_alu (
        .fields (fields.consumer),
        .hit_o  (alu_hit),
        .info_o (alu_info)
    );

    bjp_decode u_bjp (
        .fields (fields.consumer),
        .hit_o  (bjp_hit),
        .info_o (bjp_info)
    );

    mem_decode u_mem (
        .fields (fields.consumer),
        .hit_o  (mem_hit),
        .info_o (mem_info)
    );

    reg_access u_regs (
        .fields       (fields.consumer),
        .reg1_raddr_o (rs1_addr),
        .reg2_raddr_o (rs2_addr),
        .reg_waddr_o  (rd_addr),
        .reg_we_o     (rd_we)
    );

    // classes are exclusive so at most one term is nonzero
    assign info_mrg = ({rv_decode_pkg::DECINFO_W{alu_hit}} & alu_info) |
                      ({rv_decode_pkg::DECINFO_W{bjp_hit}} & bjp_info) |
                      ({rv_decode_pkg::DECINFO_W{mem_hit}} & mem_info);

    assign illegal = (info_mrg[rv_decode_pkg::INFO_GRP_MSB:0] == rv_decode_pkg::GRP_NONE);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_o    <= 1'b0;
            reg_we_o       <= 1'b0;
            illegal_inst_o <= 1'b0;
            dec_info_o     <= '0;
            dec_imm_o      <= '0;
            inst_addr_o    <= '0;
            reg1_raddr_o   <= '0;
            reg2_raddr_o   <= '0;
            reg_waddr_o    <= '0;
        end else begin
            dec_valid_o    <= inst_valid_i;
            reg_we_o       <= inst_valid_i && rd_we;    // strobe qualified
            illegal_inst_o <= inst_valid_i && illegal;
            if (inst_valid_i) begin
                dec_info_o   <= info_mrg;
                dec_imm_o    <= imm;
                inst_addr_o  <= inst_addr_i;
                reg1_raddr_o <= rs1_addr;
                reg2_raddr_o <= rs2_addr;
                reg_waddr_o  <= rd_addr;
            end
        end
    end

endmodule

/* tb_vectors.svh */
/*
 hand-written decode vectors, included inside the testbench module.
 expected values come from the RV32I encodings, not from the DUT.
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_VECS = 19;

typedef struct packed {
    logic [31:0] inst;
    logic [16:0] info;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        we;
    logic        ill;
} vec_t;

// columns: inst, info, imm, reg1, reg2, waddr, we, illegal
localparam vec_t VECTORS [NUM_VECS] = '{
    '{32'h123452B7, 17'h08009, 32'h12345000, 5'd0,  5'd0,  5'd5,  1'b1, 1'b0}, // lui x5
    '{32'hFFFFF517, 17'h18011, 32'hFFFFF000, 5'd0,  5'd0,  5'd10, 1'b1, 1'b0}, // auipc x10
    '{32'hFFB10093, 17'h08021, 32'hFFFFFFFB, 5'd2,  5'd0,  5'd1,  1'b1, 1'b0}, // addi -5
    '{32'h00721193, 17'h08081, 32'h00000007, 5'd4,  5'd0,  5'd3,  1'b1, 1'b0}, // slli 7
    '{32'h41F3D313, 17'h09001, 32'h0000001F, 5'd7,  5'd0,  5'd6,  1'b1, 1'b0}, // srai 31
    '{32'h00A48433, 17'h00021, 32'h00000000, 5'd9,  5'd10, 5'd8,  1'b1, 1'b0}, // add
    '{32'h40D605B3, 17'h00041, 32'h00000000, 5'd12, 5'd13, 5'd11, 1'b1, 1'b0}, // sub
    // plain addi to x0, no write
    '{32'h00000013, 17'h08021, 32'h00000000, 5'd0,  5'd0,  5'd0,  1'b0, 1'b0},
    '{32'hFFDFF0EF, 17'h0000A, 32'hFFFFFFFC, 5'd0,  5'd0,  5'd1,  1'b1, 1'b0}, // jal -4
    '{32'h010280E7, 17'h0040A, 32'h00000010, 5'd5,  5'd0,  5'd1,  1'b1, 1'b0}, // jalr 16
    '{32'hFE418CE3, 17'h00012, 32'hFFFFFFF8, 5'd3,  5'd4,  5'd0,  1'b0, 1'b0}, // beq -8
    '{32'hFF442383, 17'h00823, 32'hFFFFFFF4, 5'd8,  5'd0,  5'd7,  1'b1, 1'b0}, // lw -12
    '{32'h06454483, 17'h00843, 32'h00000064, 5'd10, 5'd0,  5'd9,  1'b1, 1'b0}, // lbu 100
    '{32'h00B602A3, 17'h01103, 32'h00000005, 5'd12, 5'd11, 5'd0,  1'b0, 1'b0}, // sb 5
    '{32'hFED71F23, 17'h01203, 32'hFFFFFFFE, 5'd14, 5'd13, 5'd0,  1'b0, 1'b0}, // sh -2
    '{32'h00000073, 17'h00000, 32'h00000000, 5'd0,  5'd0,  5'd0,  1'b0, 1'b1}, // ecall
    '{32'h300110F3, 17'h00000, 32'h00000000, 5'd0,  5'd0,  5'd0,  1'b0, 1'b1}, // csrrw
    // mul keeps the OP register fields, only the info is cleared
    '{32'h027302B3, 17'h00000, 32'h00000000, 5'd6,  5'd7,  5'd5,  1'b1, 1'b1},
    '{32'h0020A463, 17'h00000, 32'h00000008, 5'd1,  5'd2,  5'd0,  1'b0, 1'b1}  // br f3 010
};

`endif

/* tb_decode_stage.sv */
/*
 self-checking testbench for the decode stage, needs a simulator with timing
 support (Verilator 5 with --timing). Stops at the first mismatch.
 */
`timescale 1ns/1ns

module tb_decode_stage;

    localparam int CLK_PERIOD = 40;

    // mul x5, x6, x7 has a live rd and decodes illegal
    localparam logic [31:0] IDLE_INST = 32'h027302B3;

    logic        clk;
    logic        rst_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_valid_i;

    logic        dec_valid_o;
    logic [16:0] dec_info_o;
    logic [31:0] dec_imm_o;
    logic [31:0] inst_addr_o;
    logic [4:0]  reg1_raddr_o;
    logic [4:0]  reg2_raddr_o;
    logic [4:0]  reg_waddr_o;
    logic        reg_we_o;
    logic        illegal_inst_o;

    integer      seed;
    int          cur_row;  // row under test, for error lines

    `include "tb_vectors.svh"

    // reset, one idle check, then at most 3 cycles per row
    localparam int WATCHDOG_NS = (NUM_VECS * 4 + 10) * CLK_PERIOD;

    decode_stage uut (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_i         (inst_i),
        .inst_addr_i    (inst_addr_i),
        .inst_valid_i   (inst_valid_i),
        .dec_valid_o    (dec_valid_o),
        .dec_info_o     (dec_info_o),
        .dec_imm_o      (dec_imm_o),
        .inst_addr_o    (inst_addr_o),
        .reg1_raddr_o   (reg1_raddr_o),
        .reg2_raddr_o   (reg2_raddr_o),
        .reg_waddr_o    (reg_waddr_o),
        .reg_we_o       (reg_we_o),
        .illegal_inst_o (illegal_inst_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED at %0t ns, row %0d: %s expected 0x%0h, actual 0x%0h",
                     $time, cur_row, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "decode output mismatch");
        end
    endtask

    // registered result of one strobe
    task automatic check_row(input vec_t v, input logic [31:0] addr);
        check_value("dec_valid_o", 32'd1, 32'(dec_valid_o));
        check_value("dec_info_o", 32'(v.info), 32'(dec_info_o));
        check_value("dec_imm_o", v.imm, dec_imm_o);
        check_value("inst_addr_o", addr, inst_addr_o);
        check_value("reg1_raddr_o", 32'(v.rs1), 32'(reg1_raddr_o));
        check_value("reg2_raddr_o", 32'(v.rs2), 32'(reg2_raddr_o));
        check_value("reg_waddr_o", 32'(v.rd), 32'(reg_waddr_o));
        check_value("reg_we_o", 32'(v.we), 32'(reg_we_o));
        check_value("illegal_inst_o", 32'(v.ill), 32'(illegal_inst_o));
    endtask

    // cycle without a strobe, flags low and address held
    task automatic check_idle(input logic [31:0] held_addr);
        check_value("dec_valid_o", 32'd0, 32'(dec_valid_o));
        check_value("reg_we_o", 32'd0, 32'(reg_we_o));
        check_value("illegal_inst_o", 32'd0, 32'(illegal_inst_o));
        check_value("inst_addr_o", held_addr, inst_addr_o);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns, stopped by watchdog", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin : main_seq
        logic [31:0] addr;
        int          gap;
        seed         = 32'h2089;
        cur_row      = -1;
        clk          = 1'b0;
        rst_i        = 1'b1;
        inst_i       = '0;
        inst_addr_i  = '0;
        inst_valid_i = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        @(negedge clk);
        check_idle(32'h0);  // reset cleared address too

        for (int i = 0; i < NUM_VECS; i++) begin
            addr         = $random(seed);
            cur_row      = i;
            inst_i       = VECTORS[i].inst;
            inst_addr_i  = addr;
            inst_valid_i = 1'b1;
            @(negedge clk);
            check_row(VECTORS[i], addr);

            inst_valid_i = 1'b0;
            inst_i       = IDLE_INST;  // write and illegal must stay gated while idle
            inst_addr_i  = ~addr;
            // every fourth row goes back to back
            gap = (i % 4 == 1) ? 0 : int'($unsigned($random(seed)) % 3);
            repeat (gap) begin
                @(negedge clk);
                check_idle(addr);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
rv_decode_pkg.sv
dec_fields_if.sv
dec_field_split.sv
imm_gen.sv
alu_decode.sv
bjp_decode.sv
mem_decode.sv
reg_access.sv
decode_stage.sv
tb_decode_stage.sv

/* Makefile */
# Verilator build for the decode stage testbench
# a failing run ends in $fatal, so the sim target returns a nonzero status

TOP := tb_decode_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
